//--- filelist.f
pmu_reg_pkg.sv
pmu_pwr_pkg.sv
pmu_apb_regs.sv
pmu_wakeup.sv
pmu_pwr_seq.sv
pmu_sleep_ctrl.sv
pmu_top.sv
tb_pmu.sv

//--- pmu_apb_regs.sv
// APB register block of the PMU: control, counter reload and mode select
// also runs the event down-counter, which reads back at ADDR_CNT
`timescale 1ns/100ps
`default_nettype none

module pmu_apb_regs import pmu_reg_pkg::*; (
  input  wire                   pmu_clk,
  input  wire                   pad_cpu_rst_b,
  input  apb_req_t              i_apb,
  input  wire                   i_in_normal,
  output logic [PMU_DATA_W-1:0] o_prdata,
  output pmu_ctrl_t             o_ctrl,
  output lp_mode_t              o_lp_mode,
  output logic                  o_cnt_zero
);

  logic                  wr_en;
  logic [PMU_CNT_W-1:0]  cnt_load;
  logic [PMU_CNT_W-1:0]  cnt;
  logic                  cnt_en_ff;
  logic                  load_cnt;
  logic [PMU_DATA_W-1:0] lp_mode_sel;
  logic [PMU_DATA_W-1:0] ctrl_rd;

  assign wr_en = i_apb.sel && i_apb.write && i_apb.enable;

  // ---------------------------------------------------------------------
  // register writes
  // ---------------------------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      o_ctrl      <= '0;
      cnt_load    <= '0;
      lp_mode_sel <= '0;
    end
    else if (wr_en)
    begin
      if (i_apb.addr == ADDR_CTRL)
      begin
        o_ctrl.wic_en   <= i_apb.wdata[CTRL_WIC_BIT];
        o_ctrl.event_en <= i_apb.wdata[CTRL_EVENT_BIT];
        o_ctrl.cnt_en   <= i_apb.wdata[CTRL_CNT_BIT];
      end
      else if (i_apb.addr == ADDR_CNT)
        cnt_load <= i_apb.wdata;
      // mode can only change while the core runs
      else if (i_apb.addr == ADDR_LP_MODE && i_in_normal)
        lp_mode_sel <= i_apb.wdata;
    end
  end

  assign o_lp_mode = lp_mode_t'(lp_mode_sel[4:0]);

  // ---------------------------------------------------------------------
  // read mux
  // ---------------------------------------------------------------------
  always_comb
  begin
    ctrl_rd                 = '0;
    ctrl_rd[CTRL_WIC_BIT]   = o_ctrl.wic_en;
    ctrl_rd[CTRL_EVENT_BIT] = o_ctrl.event_en;
    ctrl_rd[CTRL_CNT_BIT]   = o_ctrl.cnt_en;
    o_prdata                = '0;
    if (i_apb.sel && !i_apb.write)
    begin
      case (i_apb.addr)
        ADDR_CTRL:    o_prdata = ctrl_rd;
        ADDR_CNT:     o_prdata = cnt;
        ADDR_LP_MODE: o_prdata = lp_mode_sel;
        default:      o_prdata = '0;
      endcase
    end
  end

  // ---------------------------------------------------------------------
  // event down-counter
  // ---------------------------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      cnt_en_ff <= 1'b0;
    else
      cnt_en_ff <= o_ctrl.cnt_en;
  end

  // reload on enable rising or on reaching zero
  assign load_cnt = (o_ctrl.cnt_en && !cnt_en_ff) || (cnt == '0);

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      cnt <= '0;
    else if (load_cnt)
      cnt <= cnt_load;
    else if (o_ctrl.cnt_en)
      cnt <= cnt - 1'b1;
  end

  assign o_cnt_zero = (cnt == '0) && o_ctrl.cnt_en;

endmodule

`default_nettype wire

//--- pmu_pwr_pkg.sv
// power side definitions: sleep states, deep-sleep step numbers
// and the power control bundle sent to the core power switch
`default_nettype none

package pmu_pwr_pkg;

  typedef enum logic [2:0] {
    NORMAL_MODE    = 3'd0,
    LIGHT_SLP      = 3'd1,
    LSLP_TO_NORMAL = 3'd2,
    DEEP_SLP       = 3'd3,
    DSLP_TO_NORMAL = 3'd4
  } sleep_state_e;

  localparam int SEQ_CNT_W = 16;

  // ---------------------------------------------------------------------
  // entry sequence steps
  // ---------------------------------------------------------------------
  localparam logic [SEQ_CNT_W-1:0] STEP_START    = 16'h0001;
  localparam logic [SEQ_CNT_W-1:0] STEP_ISO      = 16'h0020;
  localparam logic [SEQ_CNT_W-1:0] STEP_SAVE     = 16'h0040;
  localparam logic [SEQ_CNT_W-1:0] STEP_SAVE_END = 16'h0041;
  localparam logic [SEQ_CNT_W-1:0] STEP_DONE     = 16'h0060;

  // ---------------------------------------------------------------------
  // exit sequence steps, start and done are shared with entry
  // ---------------------------------------------------------------------
  localparam logic [SEQ_CNT_W-1:0] STEP_RESTORE     = 16'h0020;
  localparam logic [SEQ_CNT_W-1:0] STEP_RESTORE_END = 16'h0021;
  localparam logic [SEQ_CNT_W-1:0] STEP_ISO_OFF     = 16'h0040;

  typedef struct packed {
    logic pwr_on;
    logic iso_in;
    logic iso_out;
    logic save;
    logic restore;
  } pwr_ctl_t;

endpackage

`default_nettype wire

//--- pmu_pwr_seq.sv
// deep-sleep power sequencer, owned by the sleep controller
// steps power, isolation, save and restore on a free-running step counter
`timescale 1ns/100ps
`default_nettype none

module pmu_pwr_seq import pmu_pwr_pkg::*; (
  input  wire          pmu_clk,
  input  wire          pad_cpu_rst_b,
  input  sleep_state_e i_state,
  input  wire          i_start_in,
  input  wire          i_start_out,
  output pwr_ctl_t     o_pwr_ctl,
  output logic         o_in_done,
  output logic         o_out_done
);

  logic                 seq_en;
  logic [SEQ_CNT_W-1:0] seq_cnt;

  // ---------------------------------------------------------------------
  // step counter
  // ---------------------------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      seq_en <= 1'b0;
    else if (i_start_in || i_start_out)
      seq_en <= 1'b1;
    else if (o_in_done || o_out_done)
      seq_en <= 1'b0;
  end

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      seq_cnt <= '0;
    else if (seq_en)
      seq_cnt <= seq_cnt + 1'b1;
    else
      seq_cnt <= '0;
  end

  // ---------------------------------------------------------------------
  // power control outputs, held outside the two deep states
  // ---------------------------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      o_pwr_ctl.pwr_on  <= 1'b1;
      o_pwr_ctl.iso_in  <= 1'b0;
      o_pwr_ctl.iso_out <= 1'b0;
      o_pwr_ctl.save    <= 1'b0;
      o_pwr_ctl.restore <= 1'b0;
      o_in_done         <= 1'b0;
      o_out_done        <= 1'b0;
    end
    else if (i_state == DEEP_SLP)
    begin
      o_pwr_ctl.restore <= 1'b0;
      o_out_done        <= 1'b0;
      case (seq_cnt)
        STEP_START:
        begin
          o_pwr_ctl.pwr_on  <= 1'b1;
          o_pwr_ctl.iso_in  <= 1'b0;
          o_pwr_ctl.iso_out <= 1'b0;
          o_pwr_ctl.save    <= 1'b0;
        end
        STEP_ISO:
        begin
          o_pwr_ctl.iso_in  <= 1'b1;
          o_pwr_ctl.iso_out <= 1'b1;
        end
        STEP_SAVE:     o_pwr_ctl.save <= 1'b1;
        STEP_SAVE_END: o_pwr_ctl.save <= 1'b0;
        STEP_DONE:
        begin
          o_pwr_ctl.pwr_on <= 1'b0;
          o_in_done        <= 1'b1;
        end
        default: ;
      endcase
    end
    else if (i_state == DSLP_TO_NORMAL)
    begin
      o_pwr_ctl.save <= 1'b0;
      o_in_done      <= 1'b0;
      case (seq_cnt)
        // power back first, isolation kept until state is restored
        STEP_START:
        begin
          o_pwr_ctl.pwr_on  <= 1'b1;
          o_pwr_ctl.iso_in  <= 1'b1;
          o_pwr_ctl.iso_out <= 1'b1;
          o_pwr_ctl.restore <= 1'b0;
          o_out_done        <= 1'b0;
        end
        STEP_RESTORE:     o_pwr_ctl.restore <= 1'b1;
        STEP_RESTORE_END: o_pwr_ctl.restore <= 1'b0;
        STEP_ISO_OFF:
        begin
          o_pwr_ctl.iso_in  <= 1'b0;
          o_pwr_ctl.iso_out <= 1'b0;
        end
        STEP_DONE: o_out_done <= 1'b1;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- pmu_reg_pkg.sv
// register side definitions of the power management unit
// register map, bus widths and the APB request, control and mode structs
`default_nettype none

package pmu_reg_pkg;

  localparam int PMU_ADDR_W = 12;
  localparam int PMU_DATA_W = 32;
  localparam int PMU_CNT_W  = 32;

  // register offsets
  localparam logic [PMU_ADDR_W-1:0] ADDR_CTRL    = 12'h000;
  localparam logic [PMU_ADDR_W-1:0] ADDR_CNT     = 12'h004;
  localparam logic [PMU_ADDR_W-1:0] ADDR_LP_MODE = 12'h008;

  // control register bits, bit 2 is reserved
  localparam int CTRL_WIC_BIT   = 0;
  localparam int CTRL_EVENT_BIT = 1;
  localparam int CTRL_CNT_BIT   = 3;

  // both request bits high means the core runs
  localparam logic [1:0] LPMD_NORMAL = 2'b11;

  typedef struct packed {
    logic                  sel;
    logic                  enable;
    logic                  write;
    logic [PMU_ADDR_W-1:0] addr;
    logic [PMU_DATA_W-1:0] wdata;
  } apb_req_t;

  typedef struct packed {
    logic wic_en;
    logic event_en;
    logic cnt_en;
  } pmu_ctrl_t;

  // field order follows mode-select bits 4 down to 0
  typedef struct packed {
    logic pwr_off;
    logic ret_pwr_off;
    logic clk_off;
    logic clk_slow;
    logic normal;
  } lp_mode_t;

endpackage

`default_nettype wire

//--- pmu_sleep_ctrl.sv
// sleep state machine of the PMU
// picks light or deep sleep from the mode bits and drives the clock gates
`timescale 1ns/100ps
`default_nettype none

module pmu_sleep_ctrl import pmu_reg_pkg::*; import pmu_pwr_pkg::*; (
  input  wire        pmu_clk,
  input  wire        pad_cpu_rst_b,
  input  lp_mode_t   i_lp_mode,
  input  wire  [1:0] i_lpmd_b,
  input  wire        i_wakeup,
  output logic       o_in_normal,
  output logic       o_clk_slow,
  output logic       o_clk_off,
  output pwr_ctl_t   o_pwr_ctl
);

  sleep_state_e cur_state;
  sleep_state_e next_state;
  logic         normal_req;
  logic         start_in;
  logic         start_out;
  logic         in_done;
  logic         out_done;

  assign normal_req = (i_lpmd_b == LPMD_NORMAL);

  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      cur_state <= NORMAL_MODE;
    else
      cur_state <= next_state;
  end

  always_comb
  begin
    next_state = cur_state;
    case (cur_state)
      NORMAL_MODE:
      begin
        if (i_lp_mode.normal || normal_req)
          next_state = NORMAL_MODE;
        else if (i_lp_mode.clk_slow || i_lp_mode.clk_off)
          next_state = LIGHT_SLP;
        else if (i_lp_mode.ret_pwr_off || i_lp_mode.pwr_off)
          next_state = DEEP_SLP;
      end
      LIGHT_SLP:      if (i_wakeup) next_state = LSLP_TO_NORMAL;
      LSLP_TO_NORMAL: if (normal_req) next_state = NORMAL_MODE;
      // wakeup waits for the entry sequence to finish
      DEEP_SLP:       if (i_wakeup && in_done) next_state = DSLP_TO_NORMAL;
      DSLP_TO_NORMAL: if (normal_req && out_done) next_state = NORMAL_MODE;
      default:        next_state = NORMAL_MODE;
    endcase
  end

  assign o_in_normal = (cur_state == NORMAL_MODE);

  // clock gates
  assign o_clk_slow = (cur_state == LIGHT_SLP) && i_lp_mode.clk_slow;
  assign o_clk_off  = ((cur_state == LIGHT_SLP) && i_lp_mode.clk_off) ||
                      ((cur_state == DEEP_SLP) && i_lp_mode.ret_pwr_off);

  // one-cycle sequence starts, aligned with the state change
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
    begin
      start_in  <= 1'b0;
      start_out <= 1'b0;
    end
    else
    begin
      start_in  <= (cur_state == NORMAL_MODE) && (next_state == DEEP_SLP);
      start_out <= (cur_state == DEEP_SLP) && (next_state == DSLP_TO_NORMAL);
    end
  end

  pmu_pwr_seq u_pwr_seq (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_state       (cur_state),
    .i_start_in    (start_in),
    .i_start_out   (start_out),
    .o_pwr_ctl     (o_pwr_ctl),
    .o_in_done     (in_done),
    .o_out_done    (out_done)
  );

endmodule

`default_nettype wire

//--- pmu_top.sv
// top level of the single-core PMU
// register block and wakeup detection feed the sleep controller
`timescale 1ns/100ps
`default_nettype none

module pmu_top import pmu_reg_pkg::*; import pmu_pwr_pkg::*; (
  input  wire                   pmu_clk,
  input  wire                   pad_cpu_rst_b,
  input  apb_req_t              i_apb,
  input  wire  [1:0]            i_lpmd_b,
  input  wire                   i_intraw_vld,
  output logic [PMU_DATA_W-1:0] o_prdata,
  output logic                  o_clk_slow,
  output logic                  o_clk_off,
  output pwr_ctl_t              o_pwr_ctl
);

  pmu_ctrl_t ctrl;
  lp_mode_t  lp_mode;
  logic      cnt_zero;
  logic      in_normal;
  logic      wakeup;

  pmu_apb_regs u_apb_regs (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_apb         (i_apb),
    .i_in_normal   (in_normal),
    .o_prdata      (o_prdata),
    .o_ctrl        (ctrl),
    .o_lp_mode     (lp_mode),
    .o_cnt_zero    (cnt_zero)
  );

  pmu_wakeup u_wakeup (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_ctrl        (ctrl),
    .i_cnt_zero    (cnt_zero),
    .i_lpmd_b      (i_lpmd_b),
    .i_intraw_vld  (i_intraw_vld),
    .o_wakeup      (wakeup)
  );

  pmu_sleep_ctrl u_sleep_ctrl (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_lp_mode     (lp_mode),
    .i_lpmd_b      (i_lpmd_b),
    .i_wakeup      (wakeup),
    .o_in_normal   (in_normal),
    .o_clk_slow    (o_clk_slow),
    .o_clk_off     (o_clk_off),
    .o_pwr_ctl     (o_pwr_ctl)
  );

endmodule

`default_nettype wire

//--- pmu_wakeup.sv
// wakeup detection for the PMU
// combines the raw interrupt and the pending counter event under their enables
`timescale 1ns/100ps
`default_nettype none

module pmu_wakeup import pmu_reg_pkg::*; (
  input  wire        pmu_clk,
  input  wire        pad_cpu_rst_b,
  input  pmu_ctrl_t  i_ctrl,
  input  wire        i_cnt_zero,
  input  wire  [1:0] i_lpmd_b,
  input  wire        i_intraw_vld,
  output logic       o_wakeup
);

  logic slp_req;
  logic event_ff;
  logic event_vld;
  logic event_pending;
  logic wic_wakeup;
  logic event_wakeup;

  // any code other than run is a sleep request
  assign slp_req = (i_lpmd_b != LPMD_NORMAL);

  // interrupt source is a plain level
  assign wic_wakeup = i_intraw_vld && i_ctrl.wic_en && slp_req;

  // ---------------------------------------------------------------------
  // counter event edge and pending flag
  // ---------------------------------------------------------------------
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      event_ff <= 1'b0;
    else
      event_ff <= i_cnt_zero;
  end

  assign event_vld = i_cnt_zero && !event_ff && slp_req;

  // held until the core is back in run mode
  always_ff @(posedge pmu_clk or negedge pad_cpu_rst_b)
  begin
    if (!pad_cpu_rst_b)
      event_pending <= 1'b0;
    else if (event_vld)
      event_pending <= 1'b1;
    else if (!slp_req)
      event_pending <= 1'b0;
  end

  assign event_wakeup = event_pending && i_ctrl.event_en;

  assign o_wakeup = wic_wakeup || event_wakeup;

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the PMU testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_pmu -f filelist.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_pmu)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^Everything OK$"; then
  exit 0
fi
exit 1

//--- tb_pmu.sv
// testbench for the single-core PMU
// runs register access, light sleep, event wakeup and a deep sleep round trip
`timescale 1ns/100ps
`default_nettype none

module tb_pmu import pmu_reg_pkg::*; import pmu_pwr_pkg::*; ();

  localparam int          SEQ_CYCLES      = 'h62;
  localparam int          WATCHDOG_CYCLES = 5 * SEQ_CYCLES + 400;
  localparam logic [31:0] SEED            = 32'h28375ef8;
  localparam logic [31:0] RELOAD          = 32'd60;
  localparam pwr_ctl_t    PWR_RUN         = '{pwr_on: 1'b1, iso_in: 1'b0, iso_out: 1'b0,
                                              save: 1'b0, restore: 1'b0};

  logic                  pmu_clk;
  logic                  pad_cpu_rst_b;
  apb_req_t              apb;
  logic [1:0]            lpmd_b;
  logic                  intraw_vld;
  logic [PMU_DATA_W-1:0] prdata;
  logic                  clk_slow;
  logic                  clk_off;
  pwr_ctl_t              pwr_ctl;

  int                    n_errors = 0;
  int                    n_checks = 0;
  int                    cycle = 0;
  logic [PMU_DATA_W-1:0] rd_a;
  logic [PMU_DATA_W-1:0] rd_b;
  logic [PMU_DATA_W-1:0] mode_val;
  logic [PMU_ADDR_W-1:0] unmapped_addr;
  int                    cyc_a;
  int                    cyc_b;
  int                    iso_cyc;
  int                    save_cyc;
  int                    save_len;
  int                    pwr_cyc;
  int                    edge_cyc;
  int                    n;

  pmu_top i_pmu_top (
    .pmu_clk       (pmu_clk),
    .pad_cpu_rst_b (pad_cpu_rst_b),
    .i_apb         (apb),
    .i_lpmd_b      (lpmd_b),
    .i_intraw_vld  (intraw_vld),
    .o_prdata      (prdata),
    .o_clk_slow    (clk_slow),
    .o_clk_off     (clk_off),
    .o_pwr_ctl     (pwr_ctl)
  );

  initial
  begin
    pmu_clk = 1'b0;
    forever #2 pmu_clk = ~pmu_clk;
  end

  always @(posedge pmu_clk)
    cycle <= cycle + 1;

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge pmu_clk);
    $display("watchdog expired, the test sequence did not finish in time");
    $display("%0d checks, %0d errors", n_checks, n_errors);
    $display("Something failed");
    $finish;
  end

  // ----------------------------------------------------------------------
  // helpers
  // ----------------------------------------------------------------------
  task automatic log_error(input string msg);
    n_errors++;
    $display("CHECK FAILED @ %0d ns: %s", $time, msg);
  endtask

  task automatic check_true(input logic cond, input string msg);
    n_checks++;
    assert (cond) else log_error(msg);
  endtask

  task automatic apb_write(input logic [PMU_ADDR_W-1:0] addr,
                           input logic [PMU_DATA_W-1:0] data);
    @(negedge pmu_clk);
    apb.sel    = 1'b1;
    apb.write  = 1'b1;
    apb.enable = 1'b0;
    apb.addr   = addr;
    apb.wdata  = data;
    @(negedge pmu_clk);
    apb.enable = 1'b1;
    @(negedge pmu_clk);
    apb = '0;
  endtask

  // read data is combinational
  task automatic apb_read(input logic [PMU_ADDR_W-1:0] addr,
                          output logic [PMU_DATA_W-1:0] data);
    @(negedge pmu_clk);
    apb.sel    = 1'b1;
    apb.write  = 1'b0;
    apb.enable = 1'b0;
    apb.addr   = addr;
    #1;
    data = prdata;
    @(negedge pmu_clk);
    apb = '0;
  endtask

  task automatic wait_clk_gate(input logic use_slow, input logic level, input int limit);
    int k;
    k = 0;
    while (((use_slow ? clk_slow : clk_off) != level) && k < limit)
    begin
      @(negedge pmu_clk);
      k++;
    end
  endtask

  // ----------------------------------------------------------------------
  // power sequence properties
  // ----------------------------------------------------------------------
  a_save_iso: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    pwr_ctl.save |-> (pwr_ctl.iso_in && pwr_ctl.iso_out))
    else log_error("save high without isolation");

  a_save_pulse: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    pwr_ctl.save |=> !pwr_ctl.save)
    else log_error("save longer than one cycle");

  a_restore_iso: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    pwr_ctl.restore |-> (pwr_ctl.iso_in && pwr_ctl.iso_out && pwr_ctl.pwr_on))
    else log_error("restore high without power or isolation");

  a_off_iso: assert property (@(posedge pmu_clk) disable iff (!pad_cpu_rst_b)
    !pwr_ctl.pwr_on |-> (pwr_ctl.iso_in && pwr_ctl.iso_out))
    else log_error("core powered off without isolation");

  // ----------------------------------------------------------------------
  // test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    void'($urandom(SEED));
    pad_cpu_rst_b = 1'b0;
    apb           = '0;
    lpmd_b        = LPMD_NORMAL;
    intraw_vld    = 1'b0;
    repeat (16) @(posedge pmu_clk);
    @(negedge pmu_clk);
    pad_cpu_rst_b = 1'b1;

    // reset values and register access
    check_true(pwr_ctl == PWR_RUN, "power control not at reset value");
    check_true(!clk_slow && !clk_off, "clock gates active after reset");
    check_true(prdata == '0, "idle bus reads nonzero");
    apb_write(ADDR_CTRL, 32'hffff_ffff);
    apb_read(ADDR_CTRL, rd_a);
    check_true(rd_a == 32'h0000_000b, "control reads other than bits 0, 1 and 3");
    apb_write(ADDR_CTRL, 32'h0);
    apb_read(ADDR_CTRL, rd_a);
    check_true(rd_a == 32'h0, "control not cleared");
    mode_val = $urandom;
    apb_write(ADDR_LP_MODE, mode_val);
    apb_read(ADDR_LP_MODE, rd_a);
    check_true(rd_a == mode_val, "mode select read back wrong");
    unmapped_addr = 12'(32'h10 + $urandom_range(32'h0, 32'hfef));
    apb_read(unmapped_addr, rd_a);
    check_true(rd_a == '0, "unmapped address reads nonzero");

    // light sleep on the slow clock until the interrupt
    apb_write(ADDR_LP_MODE, 32'h2);
    apb_write(ADDR_CTRL, 32'h1);
    @(negedge pmu_clk);
    lpmd_b = 2'b00;
    wait_clk_gate(1'b1, 1'b1, 8);
    check_true(clk_slow && !clk_off, "slow clock not selected in light sleep");
    apb_write(ADDR_LP_MODE, 32'h4);
    check_true(clk_slow, "light sleep left without a wakeup");
    intraw_vld = 1'b1;
    wait_clk_gate(1'b1, 1'b0, 8);
    check_true(!clk_slow, "interrupt did not end light sleep");
    intraw_vld = 1'b0;
    apb_read(ADDR_LP_MODE, rd_a);
    check_true(rd_a == 32'h2, "mode select changed during sleep");
    lpmd_b = LPMD_NORMAL;
    apb_write(ADDR_LP_MODE, 32'h4);
    apb_read(ADDR_LP_MODE, rd_a);
    check_true(rd_a == 32'h4, "mode select write refused after wakeup");

    // event counter and event wakeup from light sleep
    apb_write(ADDR_CNT, RELOAD);
    apb_write(ADDR_CTRL, 32'ha);
    apb_read(ADDR_CNT, rd_a);
    cyc_a = cycle;
    repeat (4) @(negedge pmu_clk);
    apb_read(ADDR_CNT, rd_b);
    cyc_b = cycle;
    check_true(rd_a <= RELOAD && rd_a > 32'd8, "counter not loaded from reload value");
    check_true(rd_b == rd_a - 32'(cyc_b - cyc_a), "counter not decremented each cycle");
    lpmd_b = 2'b00;
    wait_clk_gate(1'b0, 1'b1, 8);
    check_true(clk_off && !clk_slow, "clock not gated in light sleep");
    wait_clk_gate(1'b0, 1'b0, 2 * int'(RELOAD) + 10);
    check_true(!clk_off, "counter event did not end light sleep");
    lpmd_b = LPMD_NORMAL;
    apb_write(ADDR_CTRL, 32'h1);

    // deep entry with a wakeup raised once isolation is up
    apb_write(ADDR_LP_MODE, 32'h8);
    @(negedge pmu_clk);
    lpmd_b = 2'b00;
    wait_clk_gate(1'b0, 1'b1, 8);
    check_true(clk_off, "clock not gated in deep sleep");
    edge_cyc = cycle;
    iso_cyc  = -1;
    save_cyc = -1;
    save_len = 0;
    n        = 0;
    while (pwr_ctl.pwr_on && n < 2 * SEQ_CYCLES)
    begin
      @(negedge pmu_clk);
      n++;
      if ((pwr_ctl.iso_in || pwr_ctl.iso_out) && iso_cyc < 0)
      begin
        check_true(pwr_ctl.iso_in && pwr_ctl.iso_out, "isolation rose unevenly");
        iso_cyc    = cycle;
        intraw_vld = 1'b1;
      end
      if (pwr_ctl.save)
      begin
        if (save_cyc < 0)
          save_cyc = cycle;
        save_len++;
      end
      check_true(clk_off && !pwr_ctl.restore, "exit started before power off");
    end
    check_true(!pwr_ctl.pwr_on, "power never switched off");
    check_true(iso_cyc >= 0 && save_cyc > iso_cyc, "isolation not up before save");
    check_true(save_len == 1, "save not a single-cycle pulse");
    check_true(cycle > save_cyc && !pwr_ctl.save, "power off before save ended");
    check_true(cycle - edge_cyc == SEQ_CYCLES, "entry sequence length wrong");

    // deep exit
    wait_clk_gate(1'b0, 1'b0, 8);
    check_true(!clk_off && !pwr_ctl.pwr_on, "exit did not start from power off");
    intraw_vld = 1'b0;
    pwr_cyc    = -1;
    save_cyc   = -1;
    save_len   = 0;
    n          = 0;
    while ((pwr_ctl.iso_in || pwr_ctl.iso_out) && n < 2 * SEQ_CYCLES)
    begin
      @(negedge pmu_clk);
      n++;
      check_true(!clk_off, "clock gated during exit");
      if (pwr_ctl.pwr_on && pwr_cyc < 0)
        pwr_cyc = cycle;
      if (pwr_ctl.restore)
      begin
        if (save_cyc < 0)
          save_cyc = cycle;
        save_len++;
      end
    end
    check_true(!pwr_ctl.iso_in && !pwr_ctl.iso_out, "isolation never released");
    check_true(pwr_cyc >= 0 && save_cyc > pwr_cyc, "power not back before restore");
    check_true(save_len == 1, "restore not a single-cycle pulse");
    check_true(cycle > save_cyc, "isolation released before restore");
    lpmd_b = LPMD_NORMAL;
    repeat (SEQ_CYCLES)
    begin
      @(negedge pmu_clk);
      check_true(pwr_ctl == PWR_RUN && !clk_off, "power control left run after exit");
    end
    apb_write(ADDR_LP_MODE, 32'h0);
    apb_read(ADDR_LP_MODE, rd_a);
    check_true(rd_a == 32'h0, "not back in normal mode after deep exit");

    repeat (4) @(negedge pmu_clk);
    $display("%0d checks, %0d errors", n_checks, n_errors);
    if (n_errors == 0)
      $display("Everything OK");
    else
      $display("Something failed");
    $finish;
  end

endmodule

`default_nettype wire
